// ==== include/wordmem_settings.svh ====
`ifndef WORDMEM_SETTINGS_SVH
`define WORDMEM_SETTINGS_SVH

//////////////////////////////////////////////////
// logical word geometry
//////////////////////////////////////////////////
`define WM_WIDTH      32    // bits per logical word.
`define WM_NUMWRDS    3     // words packed in one row.
`define WM_BITWRDS    2     // slot field width.
`define WM_NUMSROW    256   // physical rows.
`define WM_BITSROW    8     // row field width.
`define WM_NUMADDR    768   // logical words in total.
`define WM_BITADDR    10    // logical address width.

//////////////////////////////////////////////////
// ports and timing
//////////////////////////////////////////////////
`define WM_NUMWRPT    2     // write ports.
`define WM_NUMRDPT    2     // read ports.
`define WM_SRAM_DELAY 2     // sram read latency in cycles.

// set to 1 for an extra register on the returned rows.
`define WM_FLOPMEM    0

`endif

// ==== source/wordmem_pkg.sv ====
`default_nettype none

`include "wordmem_settings.svh"

package wordmem_pkg;

  typedef logic [`WM_WIDTH-1:0] word_t;

  // one sram row, addressed per word or as raw bits.
  typedef union packed {
    word_t [`WM_NUMWRDS-1:0]          slot;  // per-word view.
    logic [`WM_NUMWRDS*`WM_WIDTH-1:0] flat;  // bit view for masks.
  } row_u;

  typedef struct packed {
    logic                   vld;
    logic [`WM_BITADDR-1:0] adr;
    word_t                  din;
  } wr_req_t;

  typedef struct packed {
    logic                   vld;
    logic [`WM_BITADDR-1:0] adr;
  } rd_req_t;

  typedef struct packed {
    logic  vld;
    word_t dout;
  } rd_rsp_t;

  typedef struct packed {
    logic                   write;
    logic [`WM_BITSROW-1:0] row;
    row_u                   bw;
    row_u                   din;
  } mem_wr_t;

  typedef struct packed {
    logic                   read;
    logic [`WM_BITSROW-1:0] row;
  } mem_rd_t;

  typedef struct packed {
    logic [`WM_BITSROW-1:0] row;
    logic [`WM_BITWRDS-1:0] slot;
  } split_t;

  // logical address to row and word slot.
  function automatic split_t split_addr(input logic [`WM_BITADDR-1:0] adr);
    split_t sp;
    sp.row  = `WM_BITSROW'(adr / `WM_NUMWRDS);
    sp.slot = `WM_BITWRDS'(adr % `WM_NUMWRDS);
    return sp;
  endfunction

endpackage

`default_nettype wire

// ==== source/row_aligner.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "wordmem_settings.svh"

module row_aligner (
  input  logic                 clk,
  input  logic                 rst_n,
  input  wordmem_pkg::wr_req_t wr_req     [`WM_NUMWRPT],
  input  wordmem_pkg::rd_req_t rd_req     [`WM_NUMRDPT],
  output wordmem_pkg::rd_rsp_t rd_rsp     [`WM_NUMRDPT],
  output wordmem_pkg::mem_wr_t mem_wr     [`WM_NUMWRPT],
  output wordmem_pkg::mem_rd_t mem_rd     [`WM_NUMRDPT],
  input  wordmem_pkg::row_u    mem_rd_row [`WM_NUMRDPT]
);

  localparam int RD_DLY = `WM_SRAM_DELAY + `WM_FLOPMEM;  // slot pipeline depth.

  wordmem_pkg::split_t wr_sp [`WM_NUMWRPT];
  wordmem_pkg::split_t rd_sp [`WM_NUMRDPT];

  //////////////////////////////////////////////////
  // address split
  //////////////////////////////////////////////////
  always_comb begin
    for (int p = 0; p < `WM_NUMWRPT; p++) begin
      wr_sp[p] = wordmem_pkg::split_addr(wr_req[p].adr);
    end
  end

  always_comb begin
    for (int p = 0; p < `WM_NUMRDPT; p++) begin
      rd_sp[p] = wordmem_pkg::split_addr(rd_req[p].adr);
    end
  end

  //////////////////////////////////////////////////
  // write masking and same-row merge
  //////////////////////////////////////////////////
  // Ports are walked in index order. A later port that lands on the row of
  // an earlier one absorbs that write, so the SRAM sees one write per row and
  // the higher port's data wins where the masks overlap.
  always_comb begin
    for (int p = 0; p < `WM_NUMWRPT; p++) begin
      mem_wr[p] = '0;
      if (wr_req[p].vld) begin
        mem_wr[p].write = 1'b1;
        mem_wr[p].row   = wr_sp[p].row;
        mem_wr[p].bw.slot[wr_sp[p].slot]  = '1;              // one word enabled.
        mem_wr[p].din.slot[wr_sp[p].slot] = wr_req[p].din;
        for (int q = 0; q < p; q++) begin
          if (mem_wr[q].write && (mem_wr[q].row == mem_wr[p].row)) begin
            mem_wr[q].write      = 1'b0;                       // absorbed below.
            mem_wr[p].din.flat   = (mem_wr[q].din.flat & ~mem_wr[p].bw.flat) |
                                   mem_wr[p].din.flat;
            mem_wr[p].bw.flat    = mem_wr[q].bw.flat | mem_wr[p].bw.flat;
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // read path
  //////////////////////////////////////////////////
  always_comb begin
    for (int p = 0; p < `WM_NUMRDPT; p++) begin
      mem_rd[p].read = rd_req[p].vld;
      mem_rd[p].row  = rd_sp[p].row;
    end
  end

  logic                   vld_dly  [`WM_NUMRDPT][RD_DLY];
  logic [`WM_BITWRDS-1:0] slot_dly [`WM_NUMRDPT][RD_DLY];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int p = 0; p < `WM_NUMRDPT; p++) begin
        for (int s = 0; s < RD_DLY; s++) begin
          vld_dly[p][s] <= 1'b0;
        end
      end
    end else begin
      for (int p = 0; p < `WM_NUMRDPT; p++) begin
        vld_dly[p][0] <= rd_req[p].vld;
        for (int s = 1; s < RD_DLY; s++) begin
          vld_dly[p][s] <= vld_dly[p][s-1];
        end
      end
    end
  end

  // slot follows its strobe through the same number of stages.
  always_ff @(posedge clk) begin
    for (int p = 0; p < `WM_NUMRDPT; p++) begin
      slot_dly[p][0] <= rd_sp[p].slot;
      for (int s = 1; s < RD_DLY; s++) begin
        slot_dly[p][s] <= slot_dly[p][s-1];
      end
    end
  end

  wordmem_pkg::row_u rd_row [`WM_NUMRDPT];

  generate
    if (`WM_FLOPMEM != 0) begin : g_flopmem
      always_ff @(posedge clk) begin
        for (int p = 0; p < `WM_NUMRDPT; p++) begin
          rd_row[p] <= mem_rd_row[p];  // extra stage on the row data.
        end
      end
    end else begin : g_noflopmem
      always_comb begin
        for (int p = 0; p < `WM_NUMRDPT; p++) begin
          rd_row[p] = mem_rd_row[p];
        end
      end
    end
  endgenerate

  always_comb begin
    for (int p = 0; p < `WM_NUMRDPT; p++) begin
      rd_rsp[p].vld  = vld_dly[p][RD_DLY-1];
      rd_rsp[p].dout = rd_row[p].slot[slot_dly[p][RD_DLY-1]];  // word pick.
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////
  genvar gi, gj;
  generate
    for (gi = 0; gi < `WM_NUMWRPT; gi++) begin : g_wr_chk
      a_wr_adr: assert property (@(posedge clk) disable iff (!rst_n)
        wr_req[gi].vld |-> (wr_req[gi].adr < `WM_NUMADDR));
      for (gj = gi + 1; gj < `WM_NUMWRPT; gj++) begin : g_pair
        // merged writes never collide inside the SRAM.
        a_row_clash: assert property (@(posedge clk) disable iff (!rst_n)
          !(mem_wr[gi].write && mem_wr[gj].write && (mem_wr[gi].row == mem_wr[gj].row)));
      end
    end
    for (gi = 0; gi < `WM_NUMRDPT; gi++) begin : g_rd_chk
      a_rd_adr: assert property (@(posedge clk) disable iff (!rst_n)
        rd_req[gi].vld |-> (rd_req[gi].adr < `WM_NUMADDR));
    end
  endgenerate

endmodule

`default_nettype wire

// ==== source/row_sram.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "wordmem_settings.svh"

module row_sram (
  input  logic                 clk,
  input  logic                 rst_n,
  input  wordmem_pkg::mem_wr_t mem_wr     [`WM_NUMWRPT],
  input  wordmem_pkg::mem_rd_t mem_rd     [`WM_NUMRDPT],
  output wordmem_pkg::row_u    mem_rd_row [`WM_NUMRDPT]
);

  localparam int LAST = `WM_SRAM_DELAY - 1;  // output stage.

  wordmem_pkg::row_u mem     [`WM_NUMSROW];
  wordmem_pkg::row_u rd_pipe [`WM_NUMRDPT][`WM_SRAM_DELAY];
  logic              rd_vld  [`WM_NUMRDPT][`WM_SRAM_DELAY];

  //////////////////////////////////////////////////
  // bit-enabled writes
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    for (int p = 0; p < `WM_NUMWRPT; p++) begin
      if (mem_wr[p].write) begin
        mem[mem_wr[p].row] <= (mem[mem_wr[p].row].flat & ~mem_wr[p].bw.flat) |
                              (mem_wr[p].din.flat & mem_wr[p].bw.flat);
      end
    end
  end

  //////////////////////////////////////////////////
  // read pipeline
  //////////////////////////////////////////////////
  // Stage 0 samples the array on the strobe edge, before this edge's
  // writes land, which gives read-first behaviour on a row collision.
  always_ff @(posedge clk) begin
    for (int p = 0; p < `WM_NUMRDPT; p++) begin
      if (mem_rd[p].read) begin
        rd_pipe[p][0] <= mem[mem_rd[p].row];  // old row contents.
      end
      for (int s = 1; s < `WM_SRAM_DELAY; s++) begin
        rd_pipe[p][s] <= rd_pipe[p][s-1];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int p = 0; p < `WM_NUMRDPT; p++) begin
        for (int s = 0; s < `WM_SRAM_DELAY; s++) begin
          rd_vld[p][s] <= 1'b0;
        end
      end
    end else begin
      for (int p = 0; p < `WM_NUMRDPT; p++) begin
        rd_vld[p][0] <= mem_rd[p].read;
        for (int s = 1; s < `WM_SRAM_DELAY; s++) begin
          rd_vld[p][s] <= rd_vld[p][s-1];
        end
      end
    end
  end

  always_comb begin
    for (int p = 0; p < `WM_NUMRDPT; p++) begin
      mem_rd_row[p] = rd_pipe[p][LAST];
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////
  genvar gp;
  generate
    for (gp = 0; gp < `WM_NUMRDPT; gp++) begin : g_rd_chk
      a_rd_row: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rd[gp].read |-> (mem_rd[gp].row < `WM_NUMSROW));
      // returned row is the array content seen at the strobe edge.
      a_rd_data: assert property (@(posedge clk) disable iff (!rst_n)
        rd_vld[gp][LAST] |->
          (mem_rd_row[gp] === $past(mem[mem_rd[gp].row], `WM_SRAM_DELAY)));
    end
  endgenerate

endmodule

`default_nettype wire

// ==== source/wordmem_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "wordmem_settings.svh"

module wordmem_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  wordmem_pkg::wr_req_t wr_req [`WM_NUMWRPT],
  input  wordmem_pkg::rd_req_t rd_req [`WM_NUMRDPT],
  output wordmem_pkg::rd_rsp_t rd_rsp [`WM_NUMRDPT]
);

  //////////////////////////////////////////////////
  // row-level traffic between aligner and sram
  //////////////////////////////////////////////////
  wordmem_pkg::mem_wr_t mem_wr     [`WM_NUMWRPT];  // merged row writes.
  wordmem_pkg::mem_rd_t mem_rd     [`WM_NUMRDPT];  // row read strobes.
  wordmem_pkg::row_u    mem_rd_row [`WM_NUMRDPT];  // rows back from sram.

  // logical ports in, row commands out.
  row_aligner u_aligner (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_req     (wr_req),
    .rd_req     (rd_req),
    .rd_rsp     (rd_rsp),
    .mem_wr     (mem_wr),
    .mem_rd     (mem_rd),
    .mem_rd_row (mem_rd_row)
  );

  row_sram u_sram (
    .clk        (clk),
    .rst_n      (rst_n),
    .mem_wr     (mem_wr),
    .mem_rd     (mem_rd),
    .mem_rd_row (mem_rd_row)
  );

endmodule

`default_nettype wire

// ==== test/tb_wordmem.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "wordmem_settings.svh"

module tb_wordmem;

  localparam int CLK_PERIOD  = 4;
  localparam int RST_CYCLES  = 4;
  localparam int LAT         = `WM_SRAM_DELAY + `WM_FLOPMEM;  // strobe to response.
  localparam int FILL_CYCLES = `WM_NUMADDR / `WM_NUMWRPT;
  localparam int RAND_CYCLES = 3000;
  localparam int DRAIN       = LAT + 4;
  localparam int RUN_CYCLES  = RST_CYCLES + 8 + 2 * FILL_CYCLES + 16 + RAND_CYCLES + DRAIN;

  typedef struct {
    int                 due;    // cycle the response must show.
    logic               check;  // word was written before the read.
    wordmem_pkg::word_t word;
  } exp_t;

  logic                 clk = 1'b0;
  logic                 rst_n;
  wordmem_pkg::wr_req_t wr_req [`WM_NUMWRPT];
  wordmem_pkg::rd_req_t rd_req [`WM_NUMRDPT];
  wordmem_pkg::rd_rsp_t rd_rsp [`WM_NUMRDPT];

  wordmem_pkg::word_t model   [`WM_NUMADDR];
  logic               written [`WM_NUMADDR];
  exp_t               exp_q   [`WM_NUMRDPT][$];
  int                 cyc = 0;
  logic               checking = 1'b0;

  wordmem_top dut0 (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr_req (wr_req),
    .rd_req (rd_req),
    .rd_rsp (rd_rsp)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  //////////////////////////////////////////////////
  // failure reporting and compare tasks
  //////////////////////////////////////////////////
  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_word(input int p, input wordmem_pkg::word_t exp,
                            input wordmem_pkg::word_t got);
    if (got !== exp) begin
      stop_on_error($sformatf("Error: at %0t ns rd_rsp[%0d].dout expected %h, got %h",
                              $time, p, exp, got));
    end
  endtask

  task automatic check_vld(input int p, input logic exp, input logic got);
    if (got !== exp) begin
      stop_on_error($sformatf("Error: at %0t ns rd_rsp[%0d].vld expected %b, got %b",
                              $time, p, exp, got));
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus helpers and reference model
  //////////////////////////////////////////////////
  function automatic wordmem_pkg::wr_req_t make_write(input logic vld, input int adr,
                                                      input wordmem_pkg::word_t din);
    wordmem_pkg::wr_req_t w;
    w.vld = vld;
    w.adr = `WM_BITADDR'(adr);
    w.din = din;
    return w;
  endfunction

  function automatic wordmem_pkg::rd_req_t make_read(input logic vld, input int adr);
    wordmem_pkg::rd_req_t r;
    r.vld = vld;
    r.adr = `WM_BITADDR'(adr);
    return r;
  endfunction

  // expected word comes from the model before this cycle's writes.
  task automatic note_read(input int p, input wordmem_pkg::rd_req_t r);
    exp_t e;
    if (r.vld) begin
      e.due   = cyc + LAT;
      e.check = written[r.adr];
      e.word  = model[r.adr];
      exp_q[p].push_back(e);
    end
  endtask

  task automatic drive_cycle(input wordmem_pkg::wr_req_t w0, input wordmem_pkg::wr_req_t w1,
                             input wordmem_pkg::rd_req_t r0, input wordmem_pkg::rd_req_t r1);
    @(posedge clk);
    #1;
    wr_req[0] = w0;
    wr_req[1] = w1;
    rd_req[0] = r0;
    rd_req[1] = r1;
    note_read(0, r0);
    note_read(1, r1);
    if (w0.vld) begin
      model[w0.adr]   = w0.din;
      written[w0.adr] = 1'b1;
    end
    if (w1.vld) begin  // port 1 last, so it wins.
      model[w1.adr]   = w1.din;
      written[w1.adr] = 1'b1;
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) drive_cycle('0, '0, '0, '0);
  endtask

  //////////////////////////////////////////////////
  // response monitor
  //////////////////////////////////////////////////
  always @(negedge clk) begin : resp_check
    exp_t e;
    logic exp_vld;
    if (checking) begin
      for (int p = 0; p < `WM_NUMRDPT; p++) begin
        exp_vld = (exp_q[p].size() > 0) && (exp_q[p][0].due == cyc);
        check_vld(p, exp_vld, rd_rsp[p].vld);
        if (exp_vld) begin
          e = exp_q[p].pop_front();
          if (e.check) begin
            check_word(p, e.word, rd_rsp[p].dout);
          end
        end
      end
    end
  end

  initial begin : watchdog
    #(RUN_CYCLES * CLK_PERIOD * 2);
    stop_on_error("Timeout: the test sequence did not finish in time");
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////
  initial begin : main
    int                 a;
    int                 r;
    wordmem_pkg::word_t d;
    void'($urandom(27));
    rst_n = 1'b0;
    for (int p = 0; p < `WM_NUMWRPT; p++) wr_req[p] = '0;
    for (int p = 0; p < `WM_NUMRDPT; p++) rd_req[p] = '0;
    for (int i = 0; i < `WM_NUMADDR; i++) written[i] = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst_n    = 1'b1;
    checking = 1'b1;

    idle_cycles(8);  // outputs stay quiet.

    // fill every address, then read all back.
    for (int k = 0; k < FILL_CYCLES; k++) begin
      drive_cycle(make_write(1'b1, 2 * k, $urandom), make_write(1'b1, 2 * k + 1, $urandom),
                  '0, '0);
    end
    for (int k = 0; k < FILL_CYCLES; k++) begin
      drive_cycle('0, '0, make_read(1'b1, 2 * k), make_read(1'b1, 2 * k + 1));
    end

    // two slots of one row in the same cycle.
    r = int'($urandom % `WM_NUMSROW);
    drive_cycle(make_write(1'b1, 3 * r, $urandom), make_write(1'b1, 3 * r + 2, $urandom),
                '0, '0);
    drive_cycle('0, '0, make_read(1'b1, 3 * r), make_read(1'b1, 3 * r + 2));

    // both ports on one address.
    a = int'($urandom % `WM_NUMADDR);
    d = $urandom;
    drive_cycle(make_write(1'b1, a, d), make_write(1'b1, a, ~d), '0, '0);
    idle_cycles(1);
    drive_cycle('0, '0, make_read(1'b1, a), make_read(1'b1, a));

    // read-first on a collision.
    a = int'($urandom % `WM_NUMADDR);
    drive_cycle(make_write(1'b1, a, $urandom), '0, make_read(1'b1, a), '0);
    drive_cycle('0, '0, make_read(1'b1, a), make_read(1'b1, a));
    idle_cycles(DRAIN);

    // random traffic on all four ports.
    for (int k = 0; k < RAND_CYCLES; k++) begin
      drive_cycle(make_write(($urandom % 2) == 0, int'($urandom % `WM_NUMADDR), $urandom),
                  make_write(($urandom % 2) == 0, int'($urandom % `WM_NUMADDR), $urandom),
                  make_read(($urandom % 8) != 0, int'($urandom % `WM_NUMADDR)),
                  make_read(($urandom % 8) != 0, int'($urandom % `WM_NUMADDR)));
    end
    idle_cycles(DRAIN);

    if (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
      stop_on_error("Some read responses never arrived");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
source/wordmem_pkg.sv
source/row_aligner.sv
source/row_sram.sv
source/wordmem_top.sv
test/tb_wordmem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the word memory testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f flist.f --top-module tb_wordmem -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_wordmem 2>&1)
status=$?
echo "$sim_out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$sim_out" | grep -q "^NO ERRORS$"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
